// File: hdl/eth_params.svh
// Fixed widths for the 4-port 64-bit design; ETH_PORTS must stay a power of two and match ETH_PORT_BITS
`ifndef ETH_PARAMS_SVH
`define ETH_PARAMS_SVH

`define ETH_PORTS       4   // Input ports into the arbiter
`define ETH_PORT_BITS   2   // Encoded port index width
`define ETH_DATA_WIDTH  64  // Payload word width
`define ETH_KEEP_WIDTH  8   // One keep bit per payload byte
`define ETH_MAC_WIDTH   48  // Destination and source MAC
`define ETH_TYPE_WIDTH  16  // EtherType or length field, passed through undecoded

`endif

// File: hdl/eth_pkg.sv
// Shared design types; all widths come from the params header and are not parameters of any module
`include "eth_params.svh"

package eth_pkg;

    typedef logic [`ETH_MAC_WIDTH-1:0]  mac_addr_t;    // Destination or source address
    typedef logic [`ETH_TYPE_WIDTH-1:0] ether_type_t;  // Carried through as an opaque field
    typedef logic [`ETH_DATA_WIDTH-1:0] eth_data_t;    // One payload beat
    typedef logic [`ETH_KEEP_WIDTH-1:0] eth_keep_t;    // Byte enables, bit 0 is the lowest byte

    // Port indexing, encoded and one bit per port
    typedef logic [`ETH_PORT_BITS-1:0]  port_sel_t;
    typedef logic [`ETH_PORTS-1:0]      port_vec_t;    // Request, acknowledge and grant

endpackage

// File: hdl/eth_arbiter.sv
// Grant is held until the granted port acknowledges; round robin needs a power-of-two port count
`timescale 1ns/1ps
`include "eth_params.svh"

module eth_arbiter #(
    parameter string arb_type = "PRIORITY"    // "PRIORITY" or "ROUND_ROBIN"
) (
    input  logic               clk,
    input  logic               rst,
    input  eth_pkg::port_vec_t request,
    input  eth_pkg::port_vec_t acknowledge,
    output eth_pkg::port_vec_t grant,
    output logic               grant_valid,
    output eth_pkg::port_sel_t grant_sel
);

    localparam bit round_robin = (arb_type == "ROUND_ROBIN");

    eth_pkg::port_sel_t first_sel;      // Index where the winner search begins
    eth_pkg::port_sel_t cand_sel;
    eth_pkg::port_sel_t win_sel;
    logic               win_found;
    logic               release_grant;

    // **********************************************************
    // Winner selection
    // **********************************************************

    // grant_sel keeps the last granted port after the grant drops, so it
    // doubles as the rotation pointer in round-robin mode
    assign first_sel = round_robin ? eth_pkg::port_sel_t'(grant_sel + 1'b1) : '0;

    always_comb begin
        win_found = 1'b0;
        win_sel   = first_sel;
        cand_sel  = first_sel;
        for (int k = 0; k < `ETH_PORTS; k++) begin
            cand_sel = eth_pkg::port_sel_t'(first_sel + k);    // Wraps past the top port
            if (!win_found && request[cand_sel]) begin
                win_found = 1'b1;                               // First hit wins
                win_sel   = cand_sel;
            end
        end
    end

    // Only the granted port's acknowledge ends the grant
    assign release_grant = grant_valid & (|(acknowledge & grant));

    // **********************************************************
    // Grant register
    // **********************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_sel   <= '1;                  // First rotating search starts at port 0
        end else if (release_grant) begin
            grant       <= '0;                  // Idle for one clock before the next grant
            grant_valid <= 1'b0;
        end else if (!grant_valid && win_found) begin
            grant       <= eth_pkg::port_vec_t'(1) << win_sel;
            grant_valid <= 1'b1;
            grant_sel   <= win_sel;
        end
    end

endmodule

// File: hdl/eth_frame_mux.sv
// Forwards the selected port only while grant_valid is high; header must be accepted before any payload
`timescale 1ns/1ps
`include "eth_params.svh"

module eth_frame_mux (
    input  logic                                  clk,
    input  logic                                  rst,
    input  eth_pkg::port_vec_t                    in_hdr_valid,
    output eth_pkg::port_vec_t                    in_hdr_ready,
    input  eth_pkg::mac_addr_t   [`ETH_PORTS-1:0] in_dest_mac,
    input  eth_pkg::mac_addr_t   [`ETH_PORTS-1:0] in_src_mac,
    input  eth_pkg::ether_type_t [`ETH_PORTS-1:0] in_eth_type,
    input  eth_pkg::eth_data_t   [`ETH_PORTS-1:0] in_tdata,
    input  eth_pkg::eth_keep_t   [`ETH_PORTS-1:0] in_tkeep,
    input  eth_pkg::port_vec_t                    in_tvalid,
    output eth_pkg::port_vec_t                    in_tready,
    input  eth_pkg::port_vec_t                    in_tlast,
    input  eth_pkg::port_vec_t                    in_tuser,
    input  logic                                  grant_valid,
    input  eth_pkg::port_sel_t                    grant_sel,
    output logic                                  out_hdr_valid,
    input  logic                                  out_hdr_ready,
    output eth_pkg::mac_addr_t                    out_dest_mac,
    output eth_pkg::mac_addr_t                    out_src_mac,
    output eth_pkg::ether_type_t                  out_eth_type,
    output eth_pkg::eth_data_t                    out_tdata,
    output eth_pkg::eth_keep_t                    out_tkeep,
    output logic                                  out_tvalid,
    input  logic                                  out_tready,
    output logic                                  out_tlast,
    output logic                                  out_tuser
);

    eth_pkg::port_vec_t sel_onehot;         // Granted port, all zero when no grant
    logic               hdr_room;
    logic               hdr_accept;
    logic               frame_open;         // Header sent, last beat not yet taken

    logic               tready_int;         // Registered ready toward the inputs
    logic               tready_early;
    logic               beat_accept;
    eth_pkg::eth_data_t sel_tdata;
    eth_pkg::eth_keep_t sel_tkeep;
    logic               sel_tlast;
    logic               sel_tuser;

    logic               skid_valid;
    eth_pkg::eth_data_t skid_tdata;
    eth_pkg::eth_keep_t skid_tkeep;
    logic               skid_tlast;
    logic               skid_tuser;

    logic               out_tvalid_next;
    logic               skid_valid_next;
    logic               load_out_from_in;
    logic               load_skid;
    logic               load_out_from_skid;

    assign sel_onehot = eth_pkg::port_vec_t'(grant_valid) << grant_sel;

    // **********************************************************
    // Header path
    // **********************************************************

    // A new header waits for the previous frame's payload to close
    assign hdr_room     = (!out_hdr_valid || out_hdr_ready) && !frame_open;
    assign hdr_accept   = grant_valid && in_hdr_valid[grant_sel] && hdr_room;
    assign in_hdr_ready = sel_onehot & {`ETH_PORTS{hdr_room}};

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hdr_valid <= 1'b0;
        end else if (hdr_accept) begin
            out_hdr_valid <= 1'b1;
        end else if (out_hdr_ready) begin
            out_hdr_valid <= 1'b0;          // Taken by the sink
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            out_dest_mac <= in_dest_mac[grant_sel];
            out_src_mac  <= in_src_mac[grant_sel];
            out_eth_type <= in_eth_type[grant_sel];
        end
    end

    // **********************************************************
    // Payload path
    // **********************************************************

    assign sel_tdata = in_tdata[grant_sel];
    assign sel_tkeep = in_tkeep[grant_sel];
    assign sel_tlast = in_tlast[grant_sel];
    assign sel_tuser = in_tuser[grant_sel];

    assign in_tready   = sel_onehot & {`ETH_PORTS{tready_int & frame_open}};
    assign beat_accept = grant_valid && frame_open && tready_int && in_tvalid[grant_sel];

    // Ready stays up for one beat after a stall; that beat lands in the skid register
    assign tready_early = out_tready || (!skid_valid && (!out_tvalid || !beat_accept));

    always_comb begin
        out_tvalid_next    = out_tvalid;
        skid_valid_next    = skid_valid;
        load_out_from_in   = 1'b0;
        load_skid          = 1'b0;
        load_out_from_skid = 1'b0;
        if (tready_int) begin
            if (out_tready || !out_tvalid) begin
                out_tvalid_next  = beat_accept;     // Straight into the output register
                load_out_from_in = 1'b1;
            end else begin
                skid_valid_next = beat_accept;      // Output stalled so park the beat
                load_skid       = 1'b1;
            end
        end else if (out_tready) begin
            out_tvalid_next    = skid_valid;        // Drain the parked beat
            skid_valid_next    = 1'b0;
            load_out_from_skid = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
            tready_int <= 1'b0;
            out_tvalid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (hdr_accept) begin
                frame_open <= 1'b1;
            end else if (beat_accept && sel_tlast) begin
                frame_open <= 1'b0;                 // Last beat closes the frame
            end
            tready_int <= tready_early;
            out_tvalid <= out_tvalid_next;
            skid_valid <= skid_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_tdata <= sel_tdata;
            out_tkeep <= sel_tkeep;
            out_tlast <= sel_tlast;
            out_tuser <= sel_tuser;
        end else if (load_out_from_skid) begin
            out_tdata <= skid_tdata;
            out_tkeep <= skid_tkeep;
            out_tlast <= skid_tlast;
            out_tuser <= skid_tuser;
        end
        if (load_skid) begin
            skid_tdata <= sel_tdata;
            skid_tkeep <= sel_tkeep;
            skid_tlast <= sel_tlast;
            skid_tuser <= sel_tuser;
        end
    end

endmodule

// File: hdl/eth_arb_mux.sv
// Four ports onto one output, whole frames only; a port's header must precede its payload
`timescale 1ns/1ps
`include "eth_params.svh"

module eth_arb_mux #(
    parameter string arb_type = "PRIORITY"    // "PRIORITY" or "ROUND_ROBIN"
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  eth_pkg::port_vec_t                    in_hdr_valid,
    output eth_pkg::port_vec_t                    in_hdr_ready,
    input  eth_pkg::mac_addr_t   [`ETH_PORTS-1:0] in_dest_mac,
    input  eth_pkg::mac_addr_t   [`ETH_PORTS-1:0] in_src_mac,
    input  eth_pkg::ether_type_t [`ETH_PORTS-1:0] in_eth_type,
    input  eth_pkg::eth_data_t   [`ETH_PORTS-1:0] in_tdata,
    input  eth_pkg::eth_keep_t   [`ETH_PORTS-1:0] in_tkeep,
    input  eth_pkg::port_vec_t                    in_tvalid,
    output eth_pkg::port_vec_t                    in_tready,
    input  eth_pkg::port_vec_t                    in_tlast,
    input  eth_pkg::port_vec_t                    in_tuser,
    output logic                                  out_hdr_valid,
    input  logic                                  out_hdr_ready,
    output eth_pkg::mac_addr_t                    out_dest_mac,
    output eth_pkg::mac_addr_t                    out_src_mac,
    output eth_pkg::ether_type_t                  out_eth_type,
    output eth_pkg::eth_data_t                    out_tdata,
    output eth_pkg::eth_keep_t                    out_tkeep,
    output logic                                  out_tvalid,
    input  logic                                  out_tready,
    output logic                                  out_tlast,
    output logic                                  out_tuser
);

    eth_pkg::port_vec_t request;
    eth_pkg::port_vec_t acknowledge;
    eth_pkg::port_vec_t grant;
    logic               grant_valid;
    eth_pkg::port_sel_t grant_sel;
    eth_pkg::port_vec_t hdr_valid_granted;
    eth_pkg::port_vec_t tvalid_granted;

    assign request     = in_hdr_valid;                      // A pending header asks for the output
    assign acknowledge = in_tvalid & in_tready & in_tlast;  // Frame ends on its last beat
    assign hdr_valid_granted = in_hdr_valid & grant;        // Losers stay invisible to the mux
    assign tvalid_granted    = in_tvalid & grant;

    eth_arbiter #(
        .arb_type(arb_type)
    ) u_arbiter (
        .clk(clk),
        .rst(rst),
        .request(request),
        .acknowledge(acknowledge),
        .grant(grant),
        .grant_valid(grant_valid),
        .grant_sel(grant_sel)
    );

    eth_frame_mux u_frame_mux (
        .clk(clk),
        .rst(rst),
        .in_hdr_valid(hdr_valid_granted),
        .in_hdr_ready(in_hdr_ready),
        .in_dest_mac(in_dest_mac),
        .in_src_mac(in_src_mac),
        .in_eth_type(in_eth_type),
        .in_tdata(in_tdata),
        .in_tkeep(in_tkeep),
        .in_tvalid(tvalid_granted),
        .in_tready(in_tready),
        .in_tlast(in_tlast),
        .in_tuser(in_tuser),
        .grant_valid(grant_valid),
        .grant_sel(grant_sel),
        .out_hdr_valid(out_hdr_valid),
        .out_hdr_ready(out_hdr_ready),
        .out_dest_mac(out_dest_mac),
        .out_src_mac(out_src_mac),
        .out_eth_type(out_eth_type),
        .out_tdata(out_tdata),
        .out_tkeep(out_tkeep),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .out_tlast(out_tlast),
        .out_tuser(out_tuser)
    );

endmodule

// File: tb/eth_arb_mux_props.sv
// Checks handshake stability, one-hot grant and reset values; bound into every eth_arb_mux instance
`timescale 1ns/1ps

module eth_arb_mux_props (
    input logic                 clk,
    input logic                 rst,
    input eth_pkg::port_vec_t   grant,
    input logic                 grant_valid,
    input eth_pkg::port_vec_t   in_hdr_ready,
    input eth_pkg::port_vec_t   in_tready,
    input logic                 out_hdr_valid,
    input logic                 out_hdr_ready,
    input eth_pkg::mac_addr_t   out_dest_mac,
    input eth_pkg::mac_addr_t   out_src_mac,
    input eth_pkg::ether_type_t out_eth_type,
    input logic                 out_tvalid,
    input logic                 out_tready,
    input eth_pkg::eth_data_t   out_tdata,
    input eth_pkg::eth_keep_t   out_tkeep,
    input logic                 out_tlast,
    input logic                 out_tuser
);

    // Only the granted port may see a ready from the mux
    grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && ((in_hdr_ready | in_tready) & ~grant) == '0)
        else $error("grant not one-hot or a ready raised toward an ungranted port");

    // A stalled header or beat holds until the sink takes it
    hdr_stable: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_dest_mac)
            && $stable(out_src_mac) && $stable(out_eth_type))
        else $error("out_hdr changed while stalled");
    beat_stable: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
            && $stable(out_tkeep) && $stable(out_tlast) && $stable(out_tuser))
        else $error("out_t payload changed while stalled");

    reset_idle: assert property (@(posedge clk) rst |=> !out_hdr_valid && !out_tvalid
        && !grant_valid && in_hdr_ready == '0 && in_tready == '0)
        else $error("valid or ready high after reset");

endmodule

bind eth_arb_mux eth_arb_mux_props u_props (
    .clk(clk), .rst(rst), .grant(grant), .grant_valid(grant_valid),
    .in_hdr_ready(in_hdr_ready), .in_tready(in_tready),
    .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready),
    .out_dest_mac(out_dest_mac), .out_src_mac(out_src_mac), .out_eth_type(out_eth_type),
    .out_tvalid(out_tvalid), .out_tready(out_tready), .out_tdata(out_tdata),
    .out_tkeep(out_tkeep), .out_tlast(out_tlast), .out_tuser(out_tuser)
);

// File: tb/eth_arb_mux_tb.sv
// Directed tests for both arbitration modes; at most 32 frames and 512 beats per run
`timescale 1ns/1ps
`include "eth_params.svh"

module eth_arb_mux_tb #(
    parameter string arb_type = "PRIORITY"
);

    logic clk, rst, bp_en;
    eth_pkg::port_vec_t in_hdr_valid, in_hdr_ready, in_tvalid, in_tready, in_tlast, in_tuser;
    eth_pkg::mac_addr_t   [`ETH_PORTS-1:0] in_dest_mac, in_src_mac;
    eth_pkg::ether_type_t [`ETH_PORTS-1:0] in_eth_type;
    eth_pkg::eth_data_t   [`ETH_PORTS-1:0] in_tdata;
    eth_pkg::eth_keep_t   [`ETH_PORTS-1:0] in_tkeep;
    logic out_hdr_valid, out_hdr_ready, out_tvalid, out_tready, out_tlast, out_tuser;
    eth_pkg::mac_addr_t   out_dest_mac, out_src_mac;
    eth_pkg::ether_type_t out_eth_type;
    eth_pkg::eth_data_t   out_tdata;
    eth_pkg::eth_keep_t   out_tkeep;

    eth_pkg::mac_addr_t   fr_dest[32], fr_src[32];
    eth_pkg::ether_type_t fr_type[32];
    eth_pkg::eth_data_t   pool_data[512];
    eth_pkg::eth_keep_t   pool_keep[512];
    logic                 pool_user[512];
    int fr_port[32], fr_start[32], fr_len[32], hdr_cycle[32], last_cycle[32], out_cycle[512];
    int n_frames, n_beats, cycle, mismatches, failures, frames_done, hdrs_done, last_port;
    int mon_id, mon_b;
    int exp_q[$], beat_q[$];
    int beat_frame = -1;
    int beat_idx;

    eth_arb_mux #(.arb_type(arb_type)) u_eth_arb_mux (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Timeout scales with the number of beats created so far
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > 20 * n_beats + 2000) begin
            $display("Timeout after %0d cycles with %0d frames received", cycle, frames_done);
            $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        #1;
        out_tready    = bp_en ? ($urandom % 3 != 0) : 1'b1;   // Sink stalls at random when enabled
        out_hdr_ready = bp_en ? ($urandom % 2 != 0) : 1'b1;
    end

    task automatic check_hdr(input eth_pkg::mac_addr_t exp_dest,
                             input eth_pkg::mac_addr_t exp_src,
                             input eth_pkg::ether_type_t exp_type,
                             input eth_pkg::mac_addr_t act_dest,
                             input eth_pkg::mac_addr_t act_src,
                             input eth_pkg::ether_type_t act_type);
        if ({exp_dest, exp_src, exp_type} !== {act_dest, act_src, act_type}) begin
            $display(
                "mismatch at %0t: out_dest_mac/src_mac/eth_type exp %h %h %h act %h %h %h",
                $time, exp_dest, exp_src, exp_type, act_dest, act_src, act_type);
            mismatches++;
        end
    endtask

    task automatic check_beat(input eth_pkg::eth_data_t ed, input eth_pkg::eth_keep_t ek,
                              input logic el, input logic eu, input eth_pkg::eth_data_t ad,
                              input eth_pkg::eth_keep_t ak, input logic al, input logic au);
        if ({ed, ek, el, eu} !== {ad, ak, al, au}) begin
            $display(
                "mismatch at %0t: out_tdata/tkeep/tlast/tuser exp %h %h %b %b act %h %h %b %b",
                $time, ed, ek, el, eu, ad, ak, al, au);
            mismatches++;
        end
    endtask

    // Headers and payload follow the expected frame order on separate queues,
    // since a frame's beats may leave before its header is taken
    always @(negedge clk) begin
        if (!rst && out_hdr_valid && out_hdr_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected header at %0t", $time);
                failures++;
            end else begin
                mon_id = exp_q.pop_front();
                check_hdr(fr_dest[mon_id], fr_src[mon_id], fr_type[mon_id],
                          out_dest_mac, out_src_mac, out_eth_type);
                hdrs_done++;
            end
        end
        if (!rst && out_tvalid && out_tready) begin
            if (beat_frame < 0 && beat_q.size() == 0) begin
                $display("Payload beat with no frame expected at %0t", $time);
                failures++;
            end else begin
                if (beat_frame < 0) begin
                    beat_frame = beat_q.pop_front();
                    beat_idx   = 0;
                end
                mon_b = fr_start[beat_frame] + beat_idx;
                check_beat(pool_data[mon_b], pool_keep[mon_b], beat_idx == fr_len[beat_frame] - 1,
                           pool_user[mon_b], out_tdata, out_tkeep, out_tlast, out_tuser);
                out_cycle[mon_b] = cycle;
                beat_idx++;
                if (beat_idx == fr_len[beat_frame]) begin
                    frames_done++;
                    beat_frame = -1;
                end
            end
        end
    end

    function automatic int make_frame(input int p, input int len);
        int id;
        id           = n_frames;
        n_frames     = n_frames + 1;
        fr_port[id]  = p;
        fr_start[id] = n_beats;
        fr_len[id]   = len;
        fr_dest[id]  = eth_pkg::mac_addr_t'({$urandom, $urandom});
        fr_src[id]   = eth_pkg::mac_addr_t'({$urandom, $urandom});
        fr_type[id]  = eth_pkg::ether_type_t'($urandom);
        for (int k = 0; k < len; k++) begin
            pool_data[n_beats + k] = {$urandom, $urandom};
            pool_keep[n_beats + k] = (k == len - 1) ? 8'hFF >> ($urandom % 8) : 8'hFF;
            pool_user[n_beats + k] = (k == len - 1) ? 1'($urandom % 2) : 1'b0;
        end
        n_beats += len;
        return id;
    endfunction

    task automatic send_frame(input int id);
        int  p;
        bit  ok;
        p               = fr_port[id];
        in_dest_mac[p]  = fr_dest[id];
        in_src_mac[p]   = fr_src[id];
        in_eth_type[p]  = fr_type[id];
        in_hdr_valid[p] = 1'b1;
        do begin
            @(negedge clk) ok = in_hdr_ready[p];
            @(posedge clk);
            #1;
        end while (!ok);
        hdr_cycle[id]   = cycle;
        in_hdr_valid[p] = 1'b0;
        for (int k = 0; k < fr_len[id]; k++) begin
            in_tdata[p]  = pool_data[fr_start[id] + k];
            in_tkeep[p]  = pool_keep[fr_start[id] + k];
            in_tuser[p]  = pool_user[fr_start[id] + k];
            in_tlast[p]  = (k == fr_len[id] - 1);
            in_tvalid[p] = 1'b1;
            do begin
                @(negedge clk) ok = in_tready[p];
                @(posedge clk);
                #1;
            end while (!ok);
        end
        last_cycle[id] = cycle;
        in_tvalid[p]   = 1'b0;
        in_tlast[p]    = 1'b0;
    endtask

    task automatic expect_frame(input int id);
        exp_q.push_back(id);
        beat_q.push_back(id);
        last_port = fr_port[id];
    endtask

    // Returns one step after a rising edge once every header and beat has left the DUT
    task automatic wait_delivered();
        wait (frames_done == n_frames && hdrs_done == n_frames);
        @(posedge clk);
        #1;
    endtask

    task automatic run_single();
        int id;
        for (int p = 0; p < `ETH_PORTS; p++) begin
            id = make_frame(p, 2 + p);
            expect_frame(id);
            send_frame(id);
            wait_delivered();
        end
    endtask

    // All ports request on the same clock
    task automatic run_contention(input int len);
        int ids[`ETH_PORTS];
        int first;
        for (int p = 0; p < `ETH_PORTS; p++) ids[p] = make_frame(p, len + p);
        first = (arb_type == "ROUND_ROBIN") ? last_port + 1 : 0;
        for (int k = 0; k < `ETH_PORTS; k++) expect_frame(ids[(first + k) % `ETH_PORTS]);
        fork
            send_frame(ids[0]);
            send_frame(ids[1]);
            send_frame(ids[2]);
            send_frame(ids[3]);
        join
        wait_delivered();
    endtask

    task automatic run_continuity();
        int id;
        id = make_frame(1, 16);
        expect_frame(id);
        send_frame(id);
        wait_delivered();
        for (int k = 1; k < 16; k++) begin
            if (out_cycle[fr_start[id] + k] != out_cycle[fr_start[id]] + k) begin
                $display("Gap in the 16-beat frame before beat %0d", k);
                failures++;
            end
        end
    endtask

    task automatic run_late_request();
        int a, b;
        a = make_frame(3, 10);
        b = make_frame(0, 3);
        expect_frame(a);
        expect_frame(b);
        fork
            send_frame(a);
            begin
                wait (hdr_cycle[a] != 0);
                repeat (2) @(posedge clk);
                #1;
                send_frame(b);
            end
        join
        wait_delivered();
        if (hdr_cycle[b] <= last_cycle[a]) begin
            $display("Port 0 header was taken before the port 3 frame ended");
            failures++;
        end
    endtask

    initial begin
        void'($urandom(38));
        rst = 1'b1;
        bp_en = 1'b0;
        last_port = `ETH_PORTS - 1;             // First rotating search starts at port 0
        {in_hdr_valid, in_tvalid, in_tlast, in_tuser} = '0;
        {in_dest_mac, in_src_mac, in_eth_type, in_tdata, in_tkeep} = '0;
        {out_hdr_ready, out_tready} = 2'b11;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        run_single();
        run_continuity();
        run_contention(3);
        bp_en = 1'b1;
        run_contention(6);
        bp_en = 1'b0;
        run_late_request();
        repeat (5) @(posedge clk);
        if (exp_q.size() != 0 || beat_q.size() != 0 || beat_frame >= 0) begin
            $display("Frames left undelivered at the end of the run");
            failures++;
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: eth_arb_mux.f
+incdir+hdl
hdl/eth_pkg.sv
hdl/eth_arbiter.sv
hdl/eth_frame_mux.sv
hdl/eth_arb_mux.sv
tb/eth_arb_mux_props.sv
tb/eth_arb_mux_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= eth_arb_mux_tb
FILELIST  ?= eth_arb_mux.f
PASS_MSG  := Simulation completed successfully
MODES     := PRIORITY ROUND_ROBIN

.PHONY: compile run clean

compile:
	for m in $(MODES); do \
		$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Garb_type='"'$$m'"' \
			-f $(FILELIST) --Mdir obj_dir_$$m -o sim || exit 1; \
	done

run: compile
	for m in $(MODES); do \
		out=$$(./obj_dir_$$m/sim); \
		echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)" || exit 1; \
	done

clean:
	rm -rf $(addprefix obj_dir_,$(MODES))
